/* hdl/awg_pkg.sv */
// Shared sizes, trigger modes and status codes of the waveform generator; imported by RTL and testbench
package awg_pkg;

  // channel and sample geometry
  localparam int channels         = 2;
  localparam int sample_width     = 16;
  localparam int parallel_samples = 4;
  localparam int batch_width      = sample_width * parallel_samples;

  // buffer sizing, a depth counts 1..depth so it needs one bit more than an address
  localparam int depth       = 16;
  localparam int addr_width  = $clog2(depth);
  localparam int depth_width = addr_width + 1;
  localparam int burst_width = 8;

  // trigger modes, 2 bits per channel
  localparam logic [1:0] trig_none        = 2'd0;
  localparam logic [1:0] trig_once        = 2'd1;
  localparam logic [1:0] trig_every_burst = 2'd2;

  // transfer error codes reported after each load
  localparam logic [1:0] xfer_ok           = 2'd0;
  localparam logic [1:0] xfer_missing_last = 2'd1;
  localparam logic [1:0] xfer_early_last   = 2'd2;

  // start/stop command words
  localparam logic [1:0] cmd_start = 2'b10;
  localparam logic [1:0] cmd_stop  = 2'b01;

endpackage

/* hdl/awg_config_regs.sv */
// Configuration register block; captures trigger, burst and depth writes and arms the DMA loader
module awg_config_regs
  import awg_pkg::*;
(
  input  logic                             dma_clk,
  input  logic                             rst_n,
  input  logic                             trig_cfg_valid,
  output logic                             trig_cfg_ready,
  input  logic [channels*2-1:0]            trig_cfg_data,
  input  logic                             burst_len_valid,
  output logic                             burst_len_ready,
  input  logic [channels*burst_width-1:0]  burst_len_data,
  input  logic                             write_depth_valid,
  output logic                             write_depth_ready,
  input  logic [channels*depth_width-1:0]  write_depth_data,
  output logic [channels*2-1:0]            trig_mode,
  output logic [channels*burst_width-1:0]  burst_len,
  output logic [channels*depth_width-1:0]  write_depth,
  output logic                             load_arm
);

  // register writes are always accepted
  assign trig_cfg_ready    = 1'b1;
  assign burst_len_ready   = 1'b1;
  assign write_depth_ready = 1'b1;

  always_ff @(posedge dma_clk) begin
    if (!rst_n) begin
      // defaults give one batch, one burst and no triggers
      trig_mode   <= {channels{trig_none}};
      burst_len   <= {channels{burst_width'(1)}};
      write_depth <= {channels{depth_width'(1)}};
      load_arm    <= 1'b0;
    end else begin
      if (trig_cfg_valid && trig_cfg_ready) begin
        trig_mode <= trig_cfg_data;
      end
      if (burst_len_valid && burst_len_ready) begin
        burst_len <= burst_len_data;
      end
      if (write_depth_valid && write_depth_ready) begin
        write_depth <= write_depth_data;
      end
      // a new depth always starts a fresh load
      load_arm <= write_depth_valid && write_depth_ready;
    end
  end

endmodule

/* hdl/awg_dma_loader.sv */
// DMA loader; writes incoming batches into the channel buffers and reports where the last flag fell
module awg_dma_loader
  import awg_pkg::*;
(
  input  logic                             dma_clk,
  input  logic                             rst_n,
  input  logic                             load_arm,
  input  logic [channels*depth_width-1:0]  write_depth,
  input  logic                             dma_valid,
  output logic                             dma_ready,
  input  logic [batch_width-1:0]           dma_data,
  input  logic                             dma_last,
  output logic                             err_valid,
  input  logic                             err_ready,
  output logic [1:0]                       err_code,
  output logic                             buf_we,
  output logic [$clog2(channels)-1:0]      buf_channel,
  output logic [addr_width-1:0]            buf_waddr,
  output logic [batch_width-1:0]           buf_wdata
);

  enum logic [1:0] {st_idle, st_loading, st_reporting} state;

  logic [$clog2(channels)-1:0] chan;
  logic [addr_width-1:0]       addr;
  logic [depth_width-1:0]      chan_depth;
  logic                        beat;
  logic                        chan_end;
  logic                        final_beat;

  assign dma_ready  = (state == st_loading);
  assign err_valid  = (state == st_reporting);
  assign beat       = dma_valid && dma_ready;
  assign chan_depth = write_depth[chan*depth_width +: depth_width];
  assign chan_end   = ({1'b0, addr} == chan_depth - 1'b1);
  // last batch of the last channel
  assign final_beat = chan_end && (chan == channels - 1);

  // every accepted batch goes straight into the buffer
  assign buf_we      = beat;
  assign buf_channel = chan;
  assign buf_waddr   = addr;
  assign buf_wdata   = dma_data;

  always_ff @(posedge dma_clk) begin
    if (!rst_n) begin
      state <= st_idle;
      chan  <= '0;
      addr  <= '0;
    end else if (load_arm) begin
      // rearm from any state, also recovers a pending report
      state <= st_loading;
      chan  <= '0;
      addr  <= '0;
    end else begin
      case (state)
        st_loading: begin
          if (beat) begin
            if (dma_last || final_beat) begin
              state <= st_reporting;
            end else if (chan_end) begin
              chan <= chan + 1'b1;
              addr <= '0;
            end else begin
              addr <= addr + 1'b1;
            end
          end
        end
        st_reporting: begin
          if (err_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // classify the ending beat, held until the next transfer ends
  always_ff @(posedge dma_clk) begin
    if (beat && final_beat) begin
      err_code <= dma_last ? xfer_ok : xfer_missing_last;
    end else if (beat && dma_last) begin
      err_code <= xfer_early_last;
    end
  end

endmodule

/* hdl/awg_sample_buffer.sv */
// Per-channel batch memory; written by the DMA loader, read every cycle by the burst sequencer
module awg_sample_buffer
  import awg_pkg::*;
(
  input  logic                            dma_clk,
  input  logic                            buf_we,
  input  logic [$clog2(channels)-1:0]     buf_channel,
  input  logic [addr_width-1:0]           buf_waddr,
  input  logic [batch_width-1:0]          buf_wdata,
  input  logic [channels*addr_width-1:0]  rd_addr,
  output logic [channels*batch_width-1:0] rd_data
);

  for (genvar c = 0; c < channels; c++) begin : g_mem
    logic [batch_width-1:0] mem [depth];

    // write port shared by all channels, channel chosen by buf_channel
    always_ff @(posedge dma_clk) begin
      if (buf_we && (buf_channel == c)) begin
        mem[buf_waddr] <= buf_wdata;
      end
    end

    // registered read, one cycle latency
    always_ff @(posedge dma_clk) begin
      rd_data[c*batch_width +: batch_width] <= mem[rd_addr[c*addr_width +: addr_width]];
    end
  end

endmodule

/* hdl/awg_burst_sequencer.sv */
// Playback sequencer; decodes start/stop and steps read addresses and burst counts per channel
module awg_burst_sequencer
  import awg_pkg::*;
(
  input  logic                             dma_clk,
  input  logic                             rst_n,
  input  logic                             cmd_valid,
  output logic                             cmd_ready,
  input  logic [1:0]                       cmd_data,
  input  logic [channels*depth_width-1:0]  write_depth,
  input  logic [channels*burst_width-1:0]  burst_len,
  output logic [channels*addr_width-1:0]   rd_addr,
  output logic [channels-1:0]              play_active,
  output logic [channels-1:0]              first_of_burst,
  output logic [channels-1:0]              first_of_play
);

  logic [channels-1:0]    active;
  logic [addr_width-1:0]  addr  [channels];
  logic [burst_width-1:0] burst [channels];
  logic [channels-1:0]    last_addr;
  logic [channels-1:0]    last_burst;
  logic                   start;
  logic                   stop;

  // commands are always taken, a start during playback just does nothing
  assign cmd_ready = 1'b1;
  assign start     = cmd_valid && (cmd_data == cmd_start) && (active == '0);
  assign stop      = cmd_valid && (cmd_data == cmd_stop);

  always_comb begin
    for (int c = 0; c < channels; c++) begin
      last_addr[c]  = ({1'b0, addr[c]} == write_depth[c*depth_width +: depth_width] - 1'b1);
      last_burst[c] = (burst[c] == burst_len[c*burst_width +: burst_width] - 1'b1);
      rd_addr[c*addr_width +: addr_width] = addr[c];
    end
  end

  always_ff @(posedge dma_clk) begin
    if (!rst_n || stop) begin
      active <= '0;
      for (int c = 0; c < channels; c++) begin
        addr[c]  <= '0;
        burst[c] <= '0;
      end
    end else if (start) begin
      active <= '1;
      for (int c = 0; c < channels; c++) begin
        addr[c]  <= '0;
        burst[c] <= '0;
      end
    end else begin
      for (int c = 0; c < channels; c++) begin
        if (active[c]) begin
          if (last_addr[c]) begin
            addr[c] <= '0;
            // channels finish on their own schedule
            if (last_burst[c]) begin
              active[c] <= 1'b0;
              burst[c]  <= '0;
            end else begin
              burst[c] <= burst[c] + 1'b1;
            end
          end else begin
            addr[c] <= addr[c] + 1'b1;
          end
        end
      end
    end
  end

  // one cycle late so the flags meet the registered buffer read
  always_ff @(posedge dma_clk) begin
    if (!rst_n) begin
      play_active    <= '0;
      first_of_burst <= '0;
      first_of_play  <= '0;
    end else begin
      for (int c = 0; c < channels; c++) begin
        play_active[c]    <= active[c];
        first_of_burst[c] <= active[c] && (addr[c] == '0);
        first_of_play[c]  <= active[c] && (addr[c] == '0) && (burst[c] == '0);
      end
    end
  end

endmodule

/* hdl/awg_dac_output.sv */
// DAC output stage; registers sample batches, zeroes idle channels and generates trigger pulses
module awg_dac_output
  import awg_pkg::*;
(
  input  logic                             dma_clk,
  input  logic                             rst_n,
  input  logic [channels*batch_width-1:0]  rd_data,
  input  logic [channels-1:0]              play_active,
  input  logic [channels-1:0]              first_of_burst,
  input  logic [channels-1:0]              first_of_play,
  input  logic [channels*2-1:0]            trig_mode,
  output logic [channels*batch_width-1:0]  dac_data,
  output logic [channels-1:0]              dac_valid,
  output logic [channels-1:0]              dac_trigger
);

  logic [channels-1:0] trig_sel;

  // pick the pulse source per channel from its mode
  always_comb begin
    for (int c = 0; c < channels; c++) begin
      case (trig_mode[c*2 +: 2])
        trig_once:        trig_sel[c] = first_of_play[c];
        trig_every_burst: trig_sel[c] = first_of_burst[c];
        default:          trig_sel[c] = 1'b0;
      endcase
    end
  end

  always_ff @(posedge dma_clk) begin
    if (!rst_n) begin
      dac_data    <= '0;
      dac_valid   <= '0;
      dac_trigger <= '0;
    end else begin
      for (int c = 0; c < channels; c++) begin
        // idle channels drive zeros to the converter
        dac_data[c*batch_width +: batch_width] <=
          play_active[c] ? rd_data[c*batch_width +: batch_width] : '0;
        dac_valid[c]   <= play_active[c];
        dac_trigger[c] <= trig_sel[c];
      end
    end
  end

endmodule

/* hdl/awg_top.sv */
// Top level of the two-channel waveform generator; connects config, loader, buffer, sequencer and output
module awg_top
  import awg_pkg::*;
(
  input  logic                             dma_clk,
  input  logic                             rst_n,
  input  logic                             trig_cfg_valid,
  output logic                             trig_cfg_ready,
  input  logic [channels*2-1:0]            trig_cfg_data,
  input  logic                             burst_len_valid,
  output logic                             burst_len_ready,
  input  logic [channels*burst_width-1:0]  burst_len_data,
  input  logic                             write_depth_valid,
  output logic                             write_depth_ready,
  input  logic [channels*depth_width-1:0]  write_depth_data,
  input  logic                             dma_valid,
  output logic                             dma_ready,
  input  logic [batch_width-1:0]           dma_data,
  input  logic                             dma_last,
  output logic                             err_valid,
  input  logic                             err_ready,
  output logic [1:0]                       err_code,
  input  logic                             cmd_valid,
  output logic                             cmd_ready,
  input  logic [1:0]                       cmd_data,
  output logic [channels*batch_width-1:0]  dac_data,
  output logic [channels-1:0]              dac_valid,
  output logic [channels-1:0]              dac_trigger
);

  logic [channels*2-1:0]           trig_mode;
  logic [channels*burst_width-1:0] burst_len;
  logic [channels*depth_width-1:0] write_depth;
  logic                            load_arm;
  logic                            buf_we;
  logic [$clog2(channels)-1:0]     buf_channel;
  logic [addr_width-1:0]           buf_waddr;
  logic [batch_width-1:0]          buf_wdata;
  logic [channels*addr_width-1:0]  rd_addr;
  logic [channels*batch_width-1:0] rd_data;
  logic [channels-1:0]             play_active;
  logic [channels-1:0]             first_of_burst;
  logic [channels-1:0]             first_of_play;

  awg_config_regs u_config_regs (.*);

  awg_dma_loader u_dma_loader (.*);

  awg_sample_buffer u_sample_buffer (.*);

  awg_burst_sequencer u_burst_sequencer (.*);

  awg_dac_output u_dac_output (.*);

endmodule

/* verification/awg_tb_asserts.sv */
// Checker bound to awg_top; shadows config and DMA traffic at the ports and asserts on every response
module awg_tb_asserts
  import awg_pkg::*;
(
  input logic                            dma_clk, rst_n,
  input logic                            trig_cfg_valid, trig_cfg_ready,
  input logic                            burst_len_valid, burst_len_ready,
  input logic                            write_depth_valid, write_depth_ready,
  input logic                            dma_valid, dma_ready, dma_last,
  input logic                            err_valid, err_ready, cmd_valid, cmd_ready,
  input logic [channels*2-1:0]           trig_cfg_data,
  input logic [channels*burst_width-1:0] burst_len_data,
  input logic [channels*depth_width-1:0] write_depth_data,
  input logic [batch_width-1:0]          dma_data,
  input logic [1:0]                      err_code, cmd_data,
  input logic [channels*batch_width-1:0] dac_data,
  input logic [channels-1:0]             dac_valid, dac_trigger
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;
  logic [batch_width-1:0] shadow_mem [channels][depth];
  logic [1:0] trig_sh [channels];
  int burst_sh [channels];
  int depth_sh [channels];
  int pos [channels];
  int ld_chan;
  int ld_addr;
  logic load_end;
  logic [1:0] exp_code;
  logic [channels-1:0] run;
  logic [channels-1:0] exp_valid, exp_valid_d1, exp_valid_d2;
  logic [channels-1:0] exp_trig, exp_trig_d1, exp_trig_d2;
  logic [channels*batch_width-1:0] exp_data, exp_data_d1, exp_data_d2;

  // final batch of the last channel in the current load
  assign load_end = (ld_chan == channels - 1) && (ld_addr == depth_sh[ld_chan] - 1);

  // pos counts batches since start, the buffer address wraps every depth batches
  always_comb begin
    for (int c = 0; c < channels; c++) begin
      exp_valid[c] = run[c];
      exp_data[c*batch_width +: batch_width] =
        run[c] ? shadow_mem[c][pos[c] % depth_sh[c]] : '0;
      case (trig_sh[c])
        trig_once:        exp_trig[c] = run[c] && (pos[c] == 0);
        trig_every_burst: exp_trig[c] = run[c] && (pos[c] % depth_sh[c] == 0);
        default:          exp_trig[c] = 1'b0;
      endcase
    end
  end

  always @(posedge dma_clk) begin
    if (!rst_n) begin
      run <= '0;
      ld_chan <= 0;
      ld_addr <= 0;
      exp_valid_d1 <= '0;
      exp_valid_d2 <= '0;
      exp_trig_d1 <= '0;
      exp_trig_d2 <= '0;
      exp_data_d1 <= '0;
      exp_data_d2 <= '0;
      for (int c = 0; c < channels; c++) begin
        trig_sh[c] <= trig_none;
        burst_sh[c] <= 1;
        depth_sh[c] <= 1;
        pos[c] <= 0;
      end
    end else begin
      for (int c = 0; c < channels; c++) begin
        if (trig_cfg_valid && trig_cfg_ready) trig_sh[c] <= trig_cfg_data[c*2 +: 2];
        if (burst_len_valid && burst_len_ready) begin
          burst_sh[c] <= burst_len_data[c*burst_width +: burst_width];
        end
        if (write_depth_valid && write_depth_ready) begin
          depth_sh[c] <= write_depth_data[c*depth_width +: depth_width];
        end
        if (run[c]) begin
          if (pos[c] == depth_sh[c] * burst_sh[c] - 1) run[c] <= 1'b0;
          else pos[c] <= pos[c] + 1;
        end
      end
      if (write_depth_valid && write_depth_ready) begin
        ld_chan <= 0;
        ld_addr <= 0;
      end
      if (dma_valid && dma_ready) begin
        shadow_mem[ld_chan][ld_addr] <= dma_data;
        if (dma_last || load_end) begin
          exp_code <= !load_end ? xfer_early_last : (dma_last ? xfer_ok : xfer_missing_last);
        end else if (ld_addr == depth_sh[ld_chan] - 1) begin
          ld_chan <= ld_chan + 1;
          ld_addr <= 0;
        end else begin
          ld_addr <= ld_addr + 1;
        end
      end
      if (cmd_valid && cmd_ready && cmd_data == cmd_stop) begin
        run <= '0;
      end else if (cmd_valid && cmd_ready && cmd_data == cmd_start && run == '0) begin
        run <= '1;
        for (int c = 0; c < channels; c++) pos[c] <= 0;
      end
      // read issue and registered read, then the output register
      exp_valid_d1 <= exp_valid;
      exp_valid_d2 <= exp_valid_d1;
      exp_trig_d1 <= exp_trig;
      exp_trig_d2 <= exp_trig_d1;
      exp_data_d1 <= exp_data;
      exp_data_d2 <= exp_data_d1;
    end
  end

  a_ready_high: assert property (@(posedge dma_clk) disable iff (!rst_n)
    trig_cfg_ready && burst_len_ready && write_depth_ready && cmd_ready)
    else begin fail_count++; $error("a register or command port was not ready"); end

  a_dac_valid: assert property (@(posedge dma_clk) disable iff (!rst_n)
    dac_valid == exp_valid_d2)
    else begin
      fail_count++;
      $error("dac_valid expected %b actual %b", $sampled(exp_valid_d2), $sampled(dac_valid));
    end

  a_dac_data: assert property (@(posedge dma_clk) disable iff (!rst_n)
    dac_data == exp_data_d2)
    else begin
      fail_count++;
      $error("dac_data expected %h actual %h", $sampled(exp_data_d2), $sampled(dac_data));
    end

  a_dac_trigger: assert property (@(posedge dma_clk) disable iff (!rst_n)
    dac_trigger == exp_trig_d2)
    else begin
      fail_count++;
      $error("dac_trigger expected %b actual %b", $sampled(exp_trig_d2), $sampled(dac_trigger));
    end

  a_err_code: assert property (@(posedge dma_clk) disable iff (!rst_n)
    $rose(err_valid) |-> err_code == exp_code)
    else begin
      fail_count++;
      $error("err_code expected %0d actual %0d", $sampled(exp_code), $sampled(err_code));
    end

  a_err_rise: assert property (@(posedge dma_clk) disable iff (!rst_n)
    dma_valid && dma_ready && (dma_last || load_end) |=> err_valid)
    else begin fail_count++; $error("err_valid did not rise after the ending batch"); end

  a_err_hold: assert property (@(posedge dma_clk) disable iff (!rst_n)
    err_valid && !err_ready |=> err_valid)
    else begin fail_count++; $error("err_valid dropped before it was read"); end

  a_err_fall: assert property (@(posedge dma_clk) disable iff (!rst_n)
    err_valid && err_ready |=> !err_valid)
    else begin fail_count++; $error("err_valid stayed high after it was read"); end

  a_dma_blocked: assert property (@(posedge dma_clk) disable iff (!rst_n)
    err_valid |-> !dma_ready)
    else begin fail_count++; $error("dma_ready was high while an error report was pending"); end

  a_dma_armed: assert property (@(posedge dma_clk) disable iff (!rst_n)
    write_depth_valid && write_depth_ready |-> ##2 dma_ready)
    else begin fail_count++; $error("dma_ready did not rise after a write depth write"); end

endmodule

/* verification/awg_tb.sv */
// Testbench for awg_top; drives config, DMA loads and start/stop, the bound checker does the checking
module awg_tb
  import awg_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  // worst case per load with random gaps and per play with three bursts, twelve of each
  localparam int load_cycles   = 4 * depth + 16;
  localparam int play_cycles   = 3 * depth + 16;
  localparam int timeout_limit = 16 + 12 * (load_cycles + play_cycles) + 200;

  logic dma_clk;
  logic rst_n;
  logic trig_cfg_valid, burst_len_valid, write_depth_valid, dma_valid, dma_last;
  logic trig_cfg_ready, burst_len_ready, write_depth_ready, dma_ready;
  logic err_valid, err_ready, cmd_valid, cmd_ready;
  logic [channels*2-1:0] trig_cfg_data;
  logic [channels*burst_width-1:0] burst_len_data;
  logic [channels*depth_width-1:0] write_depth_data;
  logic [batch_width-1:0] dma_data;
  logic [1:0] err_code, cmd_data;
  logic [channels*batch_width-1:0] dac_data;
  logic [channels-1:0] dac_valid, dac_trigger;

  logic [31:0] seed = 32'he1d5;
  int cycles = 0;
  int fail_mark = 0;
  int wait_errors = 0;
  int passed = 0;
  int failed = 0;

  awg_top uut (.*);

  bind awg_top awg_tb_asserts chk (.*);

  always #2 dma_clk = ~dma_clk;

  always @(posedge dma_clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit) begin
      $display("timeout, the run did not finish within %0d cycles", timeout_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // zero never appears as a sample so a zero batch means blanked
  function automatic logic [batch_width-1:0] random_batch();
    logic [batch_width-1:0] b;
    logic [31:0] r;
    for (int i = 0; i < parallel_samples; i++) begin
      r = next_random();
      b[i*sample_width +: sample_width] = (r[31:16] == 0) ? 16'h1 : r[31:16];
    end
    return b;
  endfunction

  task automatic configure(input logic [1:0] t0, input logic [1:0] t1, input int b0, input int b1);
    @(posedge dma_clk);
    trig_cfg_valid <= 1'b1;
    trig_cfg_data <= {t1, t0};
    burst_len_valid <= 1'b1;
    burst_len_data <= {burst_width'(b1), burst_width'(b0)};
    @(posedge dma_clk);
    trig_cfg_valid <= 1'b0;
    burst_len_valid <= 1'b0;
  endtask

  // last_pos below zero sends no last flag, hold keeps err_ready low for that many cycles
  task automatic load(input int d0, input int d1, input int last_pos, input int hold);
    int n;
    int beats;
    @(posedge dma_clk);
    write_depth_valid <= 1'b1;
    write_depth_data <= {depth_width'(d1), depth_width'(d0)};
    @(posedge dma_clk);
    write_depth_valid <= 1'b0;
    beats = (last_pos < 0) ? d0 + d1 : last_pos + 1;
    for (n = 0; n < beats; n++) begin
      if (next_random() % 4 == 0) begin
        dma_valid <= 1'b0;
        @(posedge dma_clk);
      end
      dma_valid <= 1'b1;
      dma_data <= random_batch();
      dma_last <= (n == last_pos);
      @(negedge dma_clk);
      while (!dma_ready) @(negedge dma_clk);
      @(posedge dma_clk);
    end
    dma_valid <= 1'b0;
    dma_last <= 1'b0;
    n = 0;
    @(negedge dma_clk);
    while (!err_valid && n < 8) begin
      @(negedge dma_clk);
      n++;
    end
    if (!err_valid) begin
      $display("the transfer result was never reported");
      wait_errors++;
    end
    repeat (hold) @(posedge dma_clk);
    @(posedge dma_clk);
    err_ready <= 1'b1;
    @(posedge dma_clk);
    err_ready <= 1'b0;
  endtask

  task automatic send_cmd(input logic [1:0] code);
    @(posedge dma_clk);
    cmd_valid <= 1'b1;
    cmd_data <= code;
    @(posedge dma_clk);
    cmd_valid <= 1'b0;
  endtask

  // action 1 repeats the start mid play, action 2 stops mid play
  task automatic play(input int action);
    int n;
    int limit;
    send_cmd(cmd_start);
    n = 0;
    @(negedge dma_clk);
    while (dac_valid == '0 && n < 6) begin
      @(negedge dma_clk);
      n++;
    end
    if (dac_valid == '0) begin
      $display("playback did not start after the start command");
      wait_errors++;
    end
    if (action == 1) send_cmd(cmd_start);
    if (action == 2) begin
      repeat (6) @(posedge dma_clk);
      send_cmd(cmd_stop);
    end
    limit = (action == 2) ? 4 : play_cycles;
    n = 0;
    @(negedge dma_clk);
    while (dac_valid != '0 && n < limit) begin
      @(negedge dma_clk);
      n++;
    end
    if (dac_valid != '0) begin
      $display("playback did not end in time");
      wait_errors++;
    end
  endtask

  task automatic end_test(input string name);
    int delta;
    repeat (4) @(negedge dma_clk);
    delta = uut.chk.fail_count - fail_mark;
    fail_mark = uut.chk.fail_count;
    if (delta == 0 && wait_errors == 0) begin
      $display("%s: pass", name);
      passed++;
    end else begin
      if (delta != 0) $display("error %s: assertion failures expected 0 actual %0d", name, delta);
      $display("%s: fail", name);
      failed++;
    end
    wait_errors = 0;
  endtask

  initial begin
    int d1;
    dma_clk = 1'b0;
    rst_n = 1'b0;
    trig_cfg_valid = 1'b0;
    trig_cfg_data = '0;
    burst_len_valid = 1'b0;
    burst_len_data = '0;
    write_depth_valid = 1'b0;
    write_depth_data = '0;
    dma_valid = 1'b0;
    dma_data = '0;
    dma_last = 1'b0;
    err_ready = 1'b0;
    cmd_valid = 1'b0;
    cmd_data = '0;
    repeat (16) @(posedge dma_clk);
    rst_n <= 1'b1;

    configure(trig_once, trig_every_burst, 2, 2);
    d1 = 1 + next_random() % depth;
    load(depth, d1, depth + d1 - 1, 0);
    play(0);
    end_test("load_and_play");

    for (int k = 0; k < 3; k++) begin
      configure(2'(k), 2'((k + 1) % 3), 2, 3);
      d1 = 1 + next_random() % 8;
      load(4, d1, 3 + d1, 0);
      play(0);
    end
    end_test("trigger_modes");

    configure(trig_every_burst, trig_once, 1, 1);
    load(5, 6, -1, 4);
    load(5, 6, 2, 4);
    load(5, 6, 10, 0);
    play(0);
    end_test("transfer_errors");

    configure(trig_once, trig_every_burst, 3, 2);
    load(8, 12, 19, 0);
    play(1);
    repeat (3) play(0);
    end_test("repeated_start");

    configure(trig_none, trig_once, 1, 1);
    load(2, 16, 17, 0);
    play(2);
    end_test("stop_and_blanking");

    $display("tests passed %0d, failed %0d, assertion failures %0d", passed, failed, fail_mark);
    if (failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
hdl/awg_pkg.sv
hdl/awg_config_regs.sv
hdl/awg_dma_loader.sv
hdl/awg_sample_buffer.sv
hdl/awg_burst_sequencer.sv
hdl/awg_dac_output.sv
hdl/awg_top.sv
verification/awg_tb_asserts.sv
verification/awg_tb.sv

/* Bender.yml */
package:
  name: awg

sources:
  - hdl/awg_pkg.sv
  - hdl/awg_config_regs.sv
  - hdl/awg_dma_loader.sv
  - hdl/awg_sample_buffer.sv
  - hdl/awg_burst_sequencer.sv
  - hdl/awg_dac_output.sv
  - hdl/awg_top.sv
  - target: simulation
    files:
      - verification/awg_tb_asserts.sv
      - verification/awg_tb.sv
